// File: common/fetch_pkg.sv
package fetch_pkg;

    // Fetch start address and filler instruction
    localparam logic [31:0] reset_vector = 32'h0000_2000;
    // addi x0, x0, 0
    localparam logic [31:0] instr_nop = 32'h0000_0013;

    // Direct-mapped cache geometry, one word per line
    localparam int icache_lines = 16;
    localparam int icache_index_bits = 4;
    localparam int icache_tag_bits = 26;

    // AXI4-Lite read side constants
    localparam logic [2:0] axi_prot_instr = 3'b100;
    localparam logic [1:0] axi_resp_okay = 2'b00;

    // Trap cause, bit 31 marks an interrupt
    typedef logic [31:0] cause_t;

    localparam cause_t cause_instr_misaligned = 32'h0000_0000;
    localparam cause_t cause_instr_access_fault = 32'h0000_0001;
    localparam cause_t cause_timer_irq = 32'h8000_0007;
    localparam cause_t cause_external_irq = 32'h8000_000b;

    typedef enum logic [1:0] {
        cmd_none,
        cmd_execute,
        cmd_flush_all
    } cache_cmd_t;

    typedef enum logic [2:0] {
        rsp_idle,
        rsp_wait,
        rsp_done,
        rsp_access_fault,
        rsp_misaligned
    } cache_rsp_t;

    typedef struct packed {
        cache_cmd_t  cmd;
        logic [31:0] address;
    } cache_req_t;

    typedef struct packed {
        cache_rsp_t  rsp;
        logic [31:0] load_data;
    } cache_resp_t;

    // Slot handed to execute
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic        exc_start;
        cause_t      cause;
    } f2e_t;

    // Redirects and flow control from execute
    typedef struct packed {
        logic        ready;
        logic        exc_start;
        logic        exc_return;
        logic [31:0] epc;
        logic        flush;
        logic        branch_taken;
        logic [31:0] branch_target;
    } e2f_t;

    typedef struct packed {
        logic        request;
        logic        exit_request;
        logic        set_pc;
        logic [31:0] pc;
    } dbg_req_t;

    typedef enum logic [2:0] {
        pc_hold,
        pc_reset,
        pc_seq,
        pc_branch,
        pc_epc,
        pc_mtvec,
        pc_dbg
    } pc_src_t;

endpackage

// File: fetch/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reseted,
    input  logic        cache_ready,
    input  cache_resp_t cache_resp,
    input  e2f_t        e2f,
    input  dbg_req_t    dbg,
    input  logic        irq_timer,
    input  logic        irq_exti,
    output cache_cmd_t  cache_cmd,
    output pc_src_t     pc_src,
    output logic        take_word,
    output logic        after_flush,
    output logic        exc_start,
    output logic        dbg_mode
);

    logic reset_pending;
    logic flushing;
    logic dbg_pc_set;

    logic enter_dbg;
    logic start_flush;

    logic cache_done;
    logic cache_idle;
    logic cache_wait;
    logic cache_fault;
    logic irq_any;

    assign cache_done = cache_resp.rsp == rsp_done;
    assign cache_idle = cache_resp.rsp == rsp_idle;
    assign cache_wait = cache_resp.rsp == rsp_wait;
    assign cache_fault = (cache_resp.rsp == rsp_access_fault) ||
                         (cache_resp.rsp == rsp_misaligned);
    assign irq_any = irq_timer || irq_exti;

    always_comb begin
        cache_cmd = cmd_none;
        pc_src = pc_hold;
        take_word = 1'b0;
        exc_start = 1'b0;
        enter_dbg = 1'b0;
        start_flush = 1'b0;
        if (!cache_ready) begin
            // Cache still sweeping its valid bits
        end else if (dbg_mode && !dbg.exit_request) begin
            // Halted, only the PC may be changed
            if (dbg.set_pc) begin
                pc_src = pc_dbg;
            end
        end else if (flushing) begin
            if (!cache_done) begin
                cache_cmd = cmd_flush_all;
            end
        end else if (cache_wait) begin
            // Miss in progress, keep asking for the same word
            cache_cmd = cmd_execute;
        end else if (reset_pending || dbg_mode || cache_fault ||
                     (e2f.ready && (cache_done || cache_idle))) begin
            take_word = 1'b1;
            cache_cmd = cmd_execute;
            if (reset_pending) begin
                pc_src = pc_reset;
            end else if (dbg.request) begin
                cache_cmd = cmd_none;
                enter_dbg = 1'b1;
            end else if (irq_any) begin
                exc_start = 1'b1;
                pc_src = pc_mtvec;
            end else if (e2f.ready && e2f.exc_return) begin
                pc_src = pc_epc;
            end else if (e2f.ready && e2f.branch_taken) begin
                pc_src = pc_branch;
            end else if (e2f.ready && e2f.flush) begin
                cache_cmd = cmd_flush_all;
                start_flush = 1'b1;
            end else if (e2f.ready && e2f.exc_start) begin
                // Execute signals the trap itself
                pc_src = pc_mtvec;
            end else if (cache_fault) begin
                exc_start = 1'b1;
                pc_src = pc_mtvec;
            end else if (dbg_pc_set) begin
                // Resume at the address debug wrote, not after it
                pc_src = pc_hold;
            end else begin
                pc_src = pc_seq;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            reset_pending <= 1'b1;
            flushing <= 1'b0;
            after_flush <= 1'b0;
            dbg_mode <= 1'b0;
            dbg_pc_set <= 1'b0;
        end else if (take_word) begin
            reset_pending <= 1'b0;
            dbg_mode <= enter_dbg;
            dbg_pc_set <= 1'b0;
            // Both flags start with the flush command
            flushing <= start_flush;
            after_flush <= start_flush;
        end else begin
            if (flushing && cache_done) begin
                flushing <= 1'b0;
            end
            if (dbg_mode && dbg.set_pc) begin
                dbg_pc_set <= 1'b1;
            end
        end
    end

endmodule

// File: fetch/pc_select.sv
`timescale 1ns/1ps

module pc_select
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reseted,
    input  pc_src_t     pc_src,
    input  logic [31:0] mtvec,
    input  e2f_t        e2f,
    input  logic [31:0] dbg_pc,
    output logic [31:0] pc,
    output logic [31:0] next_pc
);

    // next_pc doubles as the cache address of this cycle
    always_comb begin
        case (pc_src)
            pc_reset: begin
                next_pc = reset_vector;
            end
            pc_seq: begin
                next_pc = pc + 32'd4;
            end
            pc_branch: begin
                next_pc = e2f.branch_target;
            end
            pc_epc: begin
                next_pc = e2f.epc;
            end
            pc_mtvec: begin
                next_pc = mtvec;
            end
            pc_dbg: begin
                next_pc = dbg_pc;
            end
            default: begin
                next_pc = pc;
            end
        endcase
    end

    // PC of the word in flight, shown to execute with its result
    always_ff @(posedge clk) begin
        if (reseted) begin
            pc <= reset_vector;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: fetch/fetch_output.sv
`timescale 1ns/1ps

module fetch_output
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reseted,
    input  cache_resp_t cache_resp,
    input  logic        dbg_mode,
    input  logic        after_flush,
    input  logic        exc_start,
    input  logic        irq_timer,
    input  logic        irq_exti,
    input  logic        e2f_exc_start,
    input  logic [31:0] pc,
    output f2e_t        f2e
);

    logic [31:0] saved_instr;

    always_comb begin
        f2e.pc = pc;
        f2e.exc_start = exc_start;
        f2e.instr = instr_nop;
        case (cache_resp.rsp)
            rsp_done: begin
                // Flush completion carries no instruction
                if (!after_flush) begin
                    f2e.instr = cache_resp.load_data;
                end
            end
            rsp_idle: begin
                // Stalled slot shows the word again
                if (!after_flush && !dbg_mode) begin
                    f2e.instr = saved_instr;
                end
            end
            default: begin
                f2e.instr = instr_nop;
            end
        endcase
    end

    // Cause only means something with exc_start
    always_comb begin
        f2e.cause = '0;
        if (!exc_start || e2f_exc_start) begin
            f2e.cause = '0;
        end else if (cache_resp.rsp == rsp_misaligned) begin
            f2e.cause = cause_instr_misaligned;
        end else if (cache_resp.rsp == rsp_access_fault) begin
            f2e.cause = cause_instr_access_fault;
        end else if (irq_exti) begin
            f2e.cause = cause_external_irq;
        end else if (irq_timer) begin
            f2e.cause = cause_timer_irq;
        end
    end

    always_ff @(posedge clk) begin
        if (reseted) begin
            saved_instr <= instr_nop;
        end else begin
            saved_instr <= f2e.instr;
        end
    end

endmodule

// File: design/icache.sv
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reseted,
    input  cache_req_t  cache_req,
    output cache_resp_t cache_resp,
    output logic        cache_ready,
    output logic [31:0] araddr,
    output logic [2:0]  arprot,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready
);

    typedef enum logic [1:0] {
        st_idle,
        st_ar,
        st_r
    } bus_state_t;

    logic [icache_tag_bits-1:0]   tag_mem [icache_lines];
    logic [31:0]                  data_mem [icache_lines];
    logic [icache_lines-1:0]      valid;

    bus_state_t                   state;
    logic                         sweeping;
    logic [icache_index_bits-1:0] sweep_idx;

    logic [icache_index_bits-1:0] req_idx;
    logic [icache_tag_bits-1:0]   req_tag;
    logic                         hit;
    logic                         fill;
    logic                         do_flush;

    assign req_idx = cache_req.address[icache_index_bits+1:2];
    assign req_tag = cache_req.address[31:icache_index_bits+2];
    assign hit = valid[req_idx] && (tag_mem[req_idx] == req_tag);
    assign fill = (state == st_r) && rvalid && (rresp == axi_resp_okay);
    assign do_flush = cache_ready && (state == st_idle) && (cache_req.cmd == cmd_flush_all);

    assign cache_ready = !sweeping;
    assign arprot = axi_prot_instr;

    // Read channel handshake and response register
    always_ff @(posedge clk) begin
        if (reseted) begin
            state <= st_idle;
            sweeping <= 1'b1;
            sweep_idx <= '0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            cache_resp.rsp <= rsp_idle;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == icache_index_bits'(icache_lines - 1)) begin
                sweeping <= 1'b0;
            end
        end else begin
            case (state)
                st_idle: begin
                    cache_resp.rsp <= rsp_idle;
                    if (cache_req.cmd == cmd_flush_all) begin
                        cache_resp.rsp <= rsp_done;
                    end else if (cache_req.cmd == cmd_execute) begin
                        if (cache_req.address[1:0] != 2'b00) begin
                            cache_resp.rsp <= rsp_misaligned;
                        end else if (hit) begin
                            cache_resp.rsp <= rsp_done;
                        end else begin
                            cache_resp.rsp <= rsp_wait;
                            arvalid <= 1'b1;
                            state <= st_ar;
                        end
                    end
                end
                st_ar: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready <= 1'b1;
                        state <= st_r;
                    end
                end
                default: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        state <= st_idle;
                        cache_resp.rsp <= (rresp == axi_resp_okay) ? rsp_done : rsp_access_fault;
                    end
                end
            endcase
        end
    end

    // Sweep, flush and fill all touch the valid bits
    always_ff @(posedge clk) begin
        if (sweeping) begin
            valid[sweep_idx] <= 1'b0;
        end else if (do_flush) begin
            valid <= '0;
        end else if (fill) begin
            valid[araddr[icache_index_bits+1:2]] <= 1'b1;
        end
    end

    // Arrays, address and returned word
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            araddr <= cache_req.address;
            cache_resp.load_data <= data_mem[req_idx];
        end
        if (fill) begin
            tag_mem[araddr[icache_index_bits+1:2]] <= araddr[31:icache_index_bits+2];
            data_mem[araddr[icache_index_bits+1:2]] <= rdata;
            cache_resp.load_data <= rdata;
        end
    end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        reseted,
    input  logic [31:0] mtvec,
    input  logic        irq_timer,
    input  logic        irq_exti,
    input  e2f_t        e2f,
    input  dbg_req_t    dbg,
    output f2e_t        f2e,
    output logic        dbg_mode,
    output logic [31:0] araddr,
    output logic [2:0]  arprot,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready
);

    cache_req_t  cache_req;
    cache_resp_t cache_resp;
    logic        cache_ready;
    cache_cmd_t  cache_cmd;
    pc_src_t     pc_src;
    logic        take_word;
    logic        after_flush;
    logic        exc_start;
    logic [31:0] pc;
    logic [31:0] next_pc;

    // Command and address meet here on their way to the cache
    assign cache_req.cmd = cache_cmd;
    assign cache_req.address = next_pc;

    fetch_ctrl fetch_ctrl_i (
        .clk         (clk),
        .reseted     (reseted),
        .cache_ready (cache_ready),
        .cache_resp  (cache_resp),
        .e2f         (e2f),
        .dbg         (dbg),
        .irq_timer   (irq_timer),
        .irq_exti    (irq_exti),
        .cache_cmd   (cache_cmd),
        .pc_src      (pc_src),
        .take_word   (take_word),
        .after_flush (after_flush),
        .exc_start   (exc_start),
        .dbg_mode    (dbg_mode)
    );

    pc_select pc_select_i (
        .clk     (clk),
        .reseted (reseted),
        .pc_src  (pc_src),
        .mtvec   (mtvec),
        .e2f     (e2f),
        .dbg_pc  (dbg.pc),
        .pc      (pc),
        .next_pc (next_pc)
    );

    fetch_output fetch_output_i (
        .clk           (clk),
        .reseted       (reseted),
        .cache_resp    (cache_resp),
        .dbg_mode      (dbg_mode),
        .after_flush   (after_flush),
        .exc_start     (exc_start),
        .irq_timer     (irq_timer),
        .irq_exti      (irq_exti),
        .e2f_exc_start (e2f.exc_start),
        .pc            (pc),
        .f2e           (f2e)
    );

    icache icache_i (
        .clk         (clk),
        .reseted     (reseted),
        .cache_req   (cache_req),
        .cache_resp  (cache_resp),
        .cache_ready (cache_ready),
        .araddr      (araddr),
        .arprot      (arprot),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready)
    );

endmodule

// File: dv/fetch_tb_asserts.sv
`timescale 1ns/1ps

module fetch_tb_asserts
    import fetch_pkg::*;
(
    input logic        clk,
    input logic        reseted,
    input logic        arvalid,
    input logic        arready,
    input logic [31:0] araddr,
    input logic        rvalid,
    input logic        rready,
    input logic        dbg_mode,
    input logic        dbg_request,
    input cache_req_t  cache_req,
    input cache_resp_t cache_resp
);

    logic outstanding;

    // One read between AR and R handshakes
    always_ff @(posedge clk) begin
        if (reseted) begin
            outstanding <= 1'b0;
        end else if (arvalid && arready) begin
            outstanding <= 1'b1;
        end else if (rvalid && rready) begin
            outstanding <= 1'b0;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (reseted)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    one_read: assert property (@(posedge clk) disable iff (reseted)
        arvalid |-> !outstanding)
        else $error("second read issued while one is outstanding");

    // Debug mode is cleared by reset and entered only on request
    dbg_reset: assert property (@(posedge clk)
        dbg_mode |-> $past(!reseted && (dbg_mode || dbg_request)))
        else $error("dbg_mode high without a debug request since reset");

    // A repeated done needs a fresh command behind it
    done_single: assert property (@(posedge clk) disable iff (reseted)
        cache_resp.rsp == rsp_done |-> $past(cache_req.cmd) != cmd_none)
        else $error("cache done held without a command");

endmodule

bind fetch_top fetch_tb_asserts fetch_tb_asserts_i (
    .clk         (clk),
    .reseted     (reseted),
    .arvalid     (arvalid),
    .arready     (arready),
    .araddr      (araddr),
    .rvalid      (rvalid),
    .rready      (rready),
    .dbg_mode    (dbg_mode),
    .dbg_request (dbg.request),
    .cache_req   (cache_req),
    .cache_resp  (cache_resp)
);

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;
    import fetch_pkg::*;

    localparam int num_slots = 2000;
    localparam int cycle_ns = 40;
    localparam int reset_cycles = 16;
    localparam logic [31:0] mtvec_addr = 32'h0000_2800;

    logic        clk;
    logic        reseted;
    logic [31:0] mtvec;
    logic        irq_timer;
    logic        irq_exti;
    e2f_t        e2f;
    dbg_req_t    dbg;
    f2e_t        f2e;
    logic        dbg_mode;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    integer seed;
    integer errors;
    integer takes;
    integer ar_count;
    integer ar_base;
    integer reset_count;

    // Reference model state
    logic        m_reset_pending;
    logic        m_dbg;
    logic        m_flush;
    logic        m_dbg_pc_set;
    logic [31:0] m_pc;
    logic        pend_valid;
    logic [31:0] pend_addr;
    logic        refetch_due;
    logic        refetch_check;

    // Memory model state
    logic        mem_busy;
    logic [31:0] mem_addr;
    integer      mem_delay;

    fetch_top fetch_top_i (
        .clk       (clk),
        .reseted   (reseted),
        .mtvec     (mtvec),
        .irq_timer (irq_timer),
        .irq_exti  (irq_exti),
        .e2f       (e2f),
        .dbg       (dbg),
        .f2e       (f2e),
        .dbg_mode  (dbg_mode),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    // Memory contents, bit 31 set so no word looks like a NOP
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] mix;
        begin
            mix = addr * 32'h9e37_79b1;
            mix = mix ^ (mix >> 13) ^ addr;
            mem_word = mix | 32'h8000_0000;
        end
    endfunction

    function automatic logic is_slverr(input logic [31:0] addr);
        is_slverr = addr[31:8] == 24'h00_0024;
    endfunction

    function automatic logic fetch_faults(input logic [31:0] addr);
        fetch_faults = (addr[1:0] != 2'b00) || is_slverr(addr);
    endfunction

    function automatic logic [31:0] rand_target();
        rand_target = 32'h0000_2000 + ($random(seed) & 32'h0000_1ffc);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors = errors + 1;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // One accepted slot, priority as seen by the fetch controller
    task automatic take_slot();
        logic        fault;
        logic        issue;
        logic        enter_dbg;
        logic        start_flush;
        logic        exp_exc;
        logic [31:0] exp_cause;
        logic [31:0] next;
        begin
            fault = pend_valid && fetch_faults(pend_addr);
            issue = 1'b1;
            enter_dbg = 1'b0;
            start_flush = 1'b0;
            exp_exc = 1'b0;
            exp_cause = '0;
            next = m_pc;
            if (pend_valid && !fault) begin
                check_value("f2e.pc", f2e.pc, pend_addr);
                check_value("f2e.instr", f2e.instr, mem_word(pend_addr));
            end
            if (fault) begin
                check_value("f2e.instr", f2e.instr, instr_nop);
            end
            // A stalled execute holds the slot unless a fault or a debug exit forces it
            if (m_dbg) begin
                check_value("dbg.exit_request at take", dbg.exit_request, 1'b1);
            end else if (!m_reset_pending && !fault) begin
                check_value("e2f.ready at take", e2f.ready, 1'b1);
            end
            // Word fetched after a flush must come over AXI again
            if (pend_valid && refetch_check && pend_addr[1:0] == 2'b00) begin
                check_value("ar_count_after_flush", ar_count > ar_base, 1);
            end
            refetch_check = 1'b0;
            if (m_reset_pending) begin
                next = reset_vector;
            end else if (dbg.request) begin
                issue = 1'b0;
                enter_dbg = 1'b1;
            end else if (irq_timer || irq_exti) begin
                exp_exc = 1'b1;
                next = mtvec;
            end else if (e2f.ready && e2f.exc_return) begin
                next = e2f.epc;
            end else if (e2f.ready && e2f.branch_taken) begin
                next = e2f.branch_target;
            end else if (e2f.ready && e2f.flush) begin
                issue = 1'b0;
                start_flush = 1'b1;
            end else if (e2f.ready && e2f.exc_start) begin
                next = mtvec;
            end else if (fault) begin
                exp_exc = 1'b1;
                next = mtvec;
            end else if (!m_dbg_pc_set) begin
                next = m_pc + 32'd4;
            end
            if (exp_exc && !e2f.exc_start) begin
                if (fault && pend_addr[1:0] != 2'b00) begin
                    exp_cause = cause_instr_misaligned;
                end else if (fault) begin
                    exp_cause = cause_instr_access_fault;
                end else if (irq_exti) begin
                    exp_cause = cause_external_irq;
                end else begin
                    exp_cause = cause_timer_irq;
                end
            end
            check_value("f2e.exc_start", f2e.exc_start, exp_exc);
            check_value("f2e.cause", f2e.cause, exp_cause);
            m_reset_pending = 1'b0;
            m_dbg = enter_dbg;
            m_flush = start_flush;
            m_dbg_pc_set = 1'b0;
            m_pc = next;
            pend_valid = issue;
            pend_addr = next;
            if (issue && refetch_due) begin
                refetch_due = 1'b0;
                refetch_check = 1'b1;
                ar_base = ar_count;
            end
            if (start_flush) begin
                refetch_due = 1'b1;
            end
            takes = takes + 1;
        end
    endtask

    always #20 clk = ~clk;

    // Stimulus and AXI slave outputs
    always @(negedge clk) begin
        if (reset_count < reset_cycles) begin
            reset_count = reset_count + 1;
            reseted = 1'b1;
        end else begin
            reseted = 1'b0;
            e2f.ready = ($random(seed) & 3) != 0;
            e2f.exc_return = ($random(seed) & 63) == 0;
            e2f.branch_taken = ($random(seed) & 15) == 0;
            e2f.flush = ($random(seed) & 63) == 0;
            e2f.exc_start = ($random(seed) & 63) == 0;
            e2f.epc = rand_target();
            e2f.branch_target = rand_target();
            // Occasional misaligned target
            if (($random(seed) & 7) == 0) begin
                e2f.branch_target = e2f.branch_target + 32'd2;
            end
            irq_timer = ($random(seed) & 63) == 0;
            irq_exti = ($random(seed) & 63) == 0;
            dbg.request = !m_dbg && (($random(seed) & 127) == 0);
            dbg.set_pc = m_dbg && (($random(seed) & 3) == 0);
            dbg.exit_request = m_dbg && !dbg.set_pc && (($random(seed) & 7) == 0);
            dbg.pc = rand_target();
            if (mem_busy) begin
                arready = 1'b0;
                if (!rvalid) begin
                    if (mem_delay == 0) begin
                        rvalid = 1'b1;
                        rdata = mem_word(mem_addr);
                        rresp = is_slverr(mem_addr) ? 2'b10 : 2'b00;
                    end else begin
                        mem_delay = mem_delay - 1;
                    end
                end
            end else begin
                arready = $random(seed) & 1;
                rvalid = 1'b0;
            end
        end
    end

    // Bus capture and model update on the rising edge
    always @(posedge clk) begin
        if (reseted) begin
            m_reset_pending = 1'b1;
            m_dbg = 1'b0;
            m_flush = 1'b0;
            m_dbg_pc_set = 1'b0;
            m_pc = reset_vector;
            pend_valid = 1'b0;
            refetch_due = 1'b0;
            refetch_check = 1'b0;
            mem_busy = 1'b0;
        end else begin
            if (arvalid) begin
                // Unprivileged secure instruction read
                check_value("arprot", arprot, 3'b100);
            end
            if (rvalid && rready) begin
                mem_busy = 1'b0;
            end
            if (arvalid && arready) begin
                mem_busy = 1'b1;
                mem_addr = araddr;
                mem_delay = ($random(seed) & 32'h7fff_ffff) % 6;
                ar_count = ar_count + 1;
            end
            check_value("dbg_mode", dbg_mode, m_dbg);
            if (m_dbg || m_flush || m_reset_pending) begin
                check_value("f2e.instr", f2e.instr, instr_nop);
            end
            if (fetch_top_i.take_word) begin
                take_slot();
            end else begin
                check_value("f2e.exc_start", f2e.exc_start, 1'b0);
                if (m_dbg && dbg.set_pc && !dbg.exit_request) begin
                    m_pc = dbg.pc;
                    m_dbg_pc_set = 1'b1;
                end
            end
        end
    end

    initial begin
        seed = 15188;
        errors = 0;
        takes = 0;
        ar_count = 0;
        ar_base = 0;
        reset_count = 0;
        clk = 1'b0;
        reseted = 1'b1;
        mtvec = mtvec_addr;
        irq_timer = 1'b0;
        irq_exti = 1'b0;
        e2f = '0;
        dbg = '0;
        arready = 1'b0;
        rdata = '0;
        rresp = 2'b00;
        rvalid = 1'b0;
        wait (takes >= num_slots);
        @(negedge clk);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized for the slot count
    initial begin
        #(num_slots * 40 * cycle_ns);
        $display("Timeout: the fetch run did not reach its last slot, only %0d taken", takes);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: fetch_sys.f
common/fetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/pc_select.sv
fetch/fetch_output.sv
design/icache.sv
design/fetch_top.sv
dv/fetch_tb_asserts.sv
dv/fetch_tb.sv
